// File: credit_params.svh
`ifndef CREDIT_PARAMS_SVH
`define CREDIT_PARAMS_SVH

// router ports
`define NUM_PORTS 5

// virtual channels per port
`define NUM_VCS 4

// flit slots per output vc
`define BUF_DEPTH 4

// must hold 0..BUF_DEPTH
`define CREDIT_W 3

`define NUM_OVCS (`NUM_PORTS * `NUM_VCS)

`endif

// File: rtl/ovc_credit_pkg.sv
`include "credit_params.svh"

package ovc_credit_pkg;

    // one bit per output vc at index port * NUM_VCS + vc
    typedef logic [`NUM_OVCS-1:0] ovc_vec_t;

    typedef struct packed {
        logic [`NUM_VCS-1:0]               granted_ivc;  // one-hot switch winner
        logic [`NUM_PORTS-1:0]             dest_port;    // one-hot
        logic [`NUM_VCS-1:0]               tail;
        logic [`NUM_VCS-1:0][`NUM_VCS-1:0] assigned_ovc; // one-hot per input vc
        logic [`NUM_VCS-1:0]               assigned;
    } port_grant_t;

    typedef port_grant_t [`NUM_PORTS-1:0] grant_bus_t;

    typedef struct packed {
        ovc_vec_t full;
        ovc_vec_t nearly_full;
    } credit_flags_t;

    typedef enum logic {
        OVC_FREE      = 1'b0,
        OVC_ALLOCATED = 1'b1
    } ovc_state_e;

    // golden file line kinds
    typedef enum logic [3:0] {
        GOLD_STIM  = 4'h1,
        GOLD_CHECK = 4'h2,
        GOLD_END   = 4'hf
    } golden_kind_e;

    typedef struct packed {
        golden_kind_e kind;
        logic [7:0]   test_id;
        grant_bus_t   grants;
        ovc_vec_t     credit_in;
        ovc_vec_t     ovc_alloc;
        ovc_vec_t     sw_grant_ivc;
        ovc_vec_t     exp_available;
        ovc_vec_t     exp_not_full;
    } golden_rec_t;

endpackage

// File: rtl/grant_decode.sv
`timescale 1ns/100ps
`include "credit_params.svh"

module grant_decode (
    input  ovc_credit_pkg::grant_bus_t grants,
    output ovc_credit_pkg::ovc_vec_t   flit_sent,
    output ovc_credit_pkg::ovc_vec_t   ovc_release
);

    localparam int P = `NUM_PORTS;
    localparam int V = `NUM_VCS;

    // per input port contributions before the merge
    ovc_credit_pkg::ovc_vec_t port_sent [P];
    ovc_credit_pkg::ovc_vec_t port_rel  [P];

    for (genvar p = 0; p < P; p++) begin : g_port
        logic [V-1:0]             sel_ovc;  // output vc held by the granted input vc
        logic                     sel_tail;
        ovc_credit_pkg::ovc_vec_t sent;

        // one-hot mux over the granted input vc
        always_comb begin
            sel_ovc  = '0;
            sel_tail = 1'b0;
            for (int iv = 0; iv < V; iv++) begin
                if (grants[p].granted_ivc[iv]) begin
                    if (grants[p].assigned[iv]) begin
                        sel_ovc = sel_ovc | grants[p].assigned_ovc[iv];
                    end
                    sel_tail = sel_tail | grants[p].tail[iv];
                end
            end
        end

        // demux into the destination port slice
        always_comb begin
            sent = '0;
            for (int dp = 0; dp < P; dp++) begin
                if (grants[p].dest_port[dp]) begin
                    sent[dp*V +: V] = sel_ovc;
                end
            end
        end

        assign port_sent[p] = sent;
        assign port_rel[p]  = sel_tail ? sent : '0;  // tail frees the vc
    end

    // at most one port targets a given output vc
    always_comb begin
        flit_sent   = '0;
        ovc_release = '0;
        for (int p = 0; p < P; p++) begin
            flit_sent   = flit_sent | port_sent[p];
            ovc_release = ovc_release | port_rel[p];
        end
    end

endmodule

// File: rtl/credit_tracker.sv
`timescale 1ns/100ps
`include "credit_params.svh"

module credit_tracker (
    input  logic                          clk,
    input  logic                          reset,
    input  ovc_credit_pkg::ovc_vec_t      flit_sent,
    input  ovc_credit_pkg::ovc_vec_t      ovc_alloc,
    input  ovc_credit_pkg::ovc_vec_t      credit_in,
    output ovc_credit_pkg::credit_flags_t flags
);

    localparam int PV = `NUM_OVCS;

    localparam logic [`CREDIT_W-1:0] CREDIT_MAX = `CREDIT_W'(`BUF_DEPTH);
    localparam logic [`CREDIT_W-1:0] CREDIT_ONE = `CREDIT_W'(1);

    logic [`CREDIT_W-1:0] credit_count      [PV];
    logic [`CREDIT_W-1:0] credit_count_next [PV];

    ovc_credit_pkg::ovc_vec_t      decrement;
    ovc_credit_pkg::credit_flags_t flags_next;

    // head flit is charged when the vc gets allocated
    assign decrement = flit_sent | ovc_alloc;

    always_comb begin
        for (int k = 0; k < PV; k++) begin
            credit_count_next[k] = credit_count[k];
            if (credit_in[k] && !decrement[k]) begin
                credit_count_next[k] = credit_count[k] + CREDIT_ONE;
            end else if (!credit_in[k] && decrement[k]) begin
                credit_count_next[k] = credit_count[k] - CREDIT_ONE;
            end
            // send and credit together cancel
        end
    end

    // flags look ahead at the next count so they line up with the counter
    always_comb begin
        for (int k = 0; k < PV; k++) begin
            flags_next.full[k]        = (credit_count_next[k] == '0);
            flags_next.nearly_full[k] = (credit_count_next[k] <= CREDIT_ONE);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < PV; k++) begin
                credit_count[k] <= CREDIT_MAX;  // buffers start empty
            end
            flags <= '0;
        end else begin
            for (int k = 0; k < PV; k++) begin
                credit_count[k] <= credit_count_next[k];
            end
            flags <= flags_next;
        end
    end

endmodule

// File: rtl/ovc_status_tracker.sv
`timescale 1ns/100ps
`include "credit_params.svh"

module ovc_status_tracker (
    input  logic                     clk,
    input  logic                     reset,
    input  ovc_credit_pkg::ovc_vec_t ovc_alloc,
    input  ovc_credit_pkg::ovc_vec_t ovc_release,
    output ovc_credit_pkg::ovc_vec_t ovc_status
);

    localparam int PV = `NUM_OVCS;

    ovc_credit_pkg::ovc_vec_t status_next;

    always_comb begin
        for (int k = 0; k < PV; k++) begin : g_bit
            ovc_credit_pkg::ovc_state_e state;

            state = ovc_credit_pkg::ovc_state_e'(ovc_status[k]);
            if (ovc_release[k]) begin
                state = ovc_credit_pkg::OVC_FREE;
            end
            if (ovc_alloc[k]) begin
                state = ovc_credit_pkg::OVC_ALLOCATED;  // allocation wins
            end
            status_next[k] = (state == ovc_credit_pkg::OVC_ALLOCATED);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovc_status <= '0;  // all vcs free
        end else begin
            ovc_status <= status_next;
        end
    end

endmodule

// File: rtl/ovc_readiness.sv
`timescale 1ns/100ps
`include "credit_params.svh"

module ovc_readiness (
    input  logic                          clk,
    input  logic                          reset,
    input  ovc_credit_pkg::credit_flags_t flags,
    input  ovc_credit_pkg::ovc_vec_t      ovc_status,
    input  ovc_credit_pkg::ovc_vec_t      credit_in,
    input  ovc_credit_pkg::grant_bus_t    grants,
    input  ovc_credit_pkg::ovc_vec_t      sw_grant_ivc,
    output ovc_credit_pkg::ovc_vec_t      ovc_available,
    output ovc_credit_pkg::ovc_vec_t      assigned_ovc_not_full
);

    localparam int P  = `NUM_PORTS;
    localparam int V  = `NUM_VCS;
    localparam int PV = `NUM_OVCS;

    ovc_credit_pkg::ovc_vec_t full_live;   // flags minus credits arriving now
    ovc_credit_pkg::ovc_vec_t nfull_live;
    ovc_credit_pkg::ovc_vec_t full_hit;    // indexed by input vc
    ovc_credit_pkg::ovc_vec_t nfull_hit;
    ovc_credit_pkg::ovc_vec_t full_q;
    ovc_credit_pkg::ovc_vec_t nfull_q;

    logic [P-1:0] dest_cur [PV];
    logic [P-1:0] dest_q   [PV];  // last granted destination per input vc

    // non-atomic reuse, partially adaptive
    assign ovc_available = ~(ovc_status | flags.nearly_full);

    assign full_live  = flags.full & ~credit_in;
    assign nfull_live = flags.nearly_full & ~credit_in;

    for (genvar i = 0; i < PV; i++) begin : g_ivc
        localparam int IP = i / V;
        localparam int IV = i % V;

        logic [V-1:0] ovc_sel;
        logic [V-1:0] full_port;
        logic [V-1:0] nfull_port;

        assign dest_cur[i] = grants[IP].granted_ivc[IV] ? grants[IP].dest_port : dest_q[i];
        // unassigned input vc points nowhere
        assign ovc_sel = grants[IP].assigned[IV] ? grants[IP].assigned_ovc[IV] : '0;

        // destination port mux
        always_comb begin
            full_port  = '0;
            nfull_port = '0;
            for (int dp = 0; dp < P; dp++) begin
                if (dest_cur[i][dp]) begin
                    full_port  = full_port | full_live[dp*V +: V];
                    nfull_port = nfull_port | nfull_live[dp*V +: V];
                end
            end
        end

        // then the assigned vc
        assign full_hit[i]  = |(full_port & ovc_sel);
        assign nfull_hit[i] = |(nfull_port & ovc_sel);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_q  <= '0;
            nfull_q <= '0;
            for (int i = 0; i < PV; i++) begin
                dest_q[i] <= '0;
            end
        end else begin
            full_q  <= full_hit;
            nfull_q <= nfull_hit & sw_grant_ivc;  // last slot about to be used
            for (int i = 0; i < PV; i++) begin
                dest_q[i] <= dest_cur[i];
            end
        end
    end

    assign assigned_ovc_not_full = ~(full_q | nfull_q);

endmodule

// File: rtl/ovc_credit_top.sv
`timescale 1ns/100ps

module ovc_credit_top (
    input  logic                       clk,
    input  logic                       reset,
    input  ovc_credit_pkg::grant_bus_t grants,
    input  ovc_credit_pkg::ovc_vec_t   credit_in,
    input  ovc_credit_pkg::ovc_vec_t   ovc_alloc,
    input  ovc_credit_pkg::ovc_vec_t   sw_grant_ivc,
    output ovc_credit_pkg::ovc_vec_t   ovc_available,
    output ovc_credit_pkg::ovc_vec_t   assigned_ovc_not_full
);

    ovc_credit_pkg::ovc_vec_t      flit_sent;
    ovc_credit_pkg::ovc_vec_t      ovc_release;
    ovc_credit_pkg::ovc_vec_t      ovc_status;
    ovc_credit_pkg::credit_flags_t flags;

    // switch grants to per output vc strobes
    grant_decode u_grant_decode (
        .grants      (grants),
        .flit_sent   (flit_sent),
        .ovc_release (ovc_release)
    );

    credit_tracker u_credit_tracker (
        .clk       (clk),
        .reset     (reset),
        .flit_sent (flit_sent),
        .ovc_alloc (ovc_alloc),
        .credit_in (credit_in),
        .flags     (flags)
    );

    ovc_status_tracker u_ovc_status_tracker (
        .clk         (clk),
        .reset       (reset),
        .ovc_alloc   (ovc_alloc),
        .ovc_release (ovc_release),
        .ovc_status  (ovc_status)
    );

    ovc_readiness u_ovc_readiness (
        .clk                   (clk),
        .reset                 (reset),
        .flags                 (flags),
        .ovc_status            (ovc_status),
        .credit_in             (credit_in),
        .grants                (grants),
        .sw_grant_ivc          (sw_grant_ivc),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

endmodule

// File: verification/ovc_credit_props.sv
`timescale 1ns/100ps
`include "credit_params.svh"

module ovc_credit_props #(
    parameter bit CREDIT_RULES = 1'b1,  // counter checks
    parameter bit STATUS_RULES = 1'b1   // allocation and release checks
) (
    input logic                     clk,
    input logic                     reset,
    input ovc_credit_pkg::ovc_vec_t decrement,
    input ovc_credit_pkg::ovc_vec_t credit_in,
    input logic [`CREDIT_W-1:0]     credit_count [`NUM_OVCS],
    input ovc_credit_pkg::ovc_vec_t ovc_alloc,
    input ovc_credit_pkg::ovc_vec_t ovc_release,
    input ovc_credit_pkg::ovc_vec_t ovc_status
);

    if (CREDIT_RULES) begin : g_credit
        ovc_credit_pkg::ovc_vec_t at_zero;  // no credits left
        ovc_credit_pkg::ovc_vec_t at_max;   // downstream buffer empty

        always_comb begin
            for (int k = 0; k < `NUM_OVCS; k++) begin
                at_zero[k] = (credit_count[k] == '0);
                at_max[k]  = (credit_count[k] == `CREDIT_W'(`BUF_DEPTH));
            end
        end

        // a send in the same cycle cancels the credit
        credit_overflow: assert property (@(posedge clk) disable iff (reset)
            (credit_in & ~decrement & at_max) == '0)
            else $error("credit returned to an output vc that holds all its credits");

        send_underflow: assert property (@(posedge clk) disable iff (reset)
            (decrement & ~credit_in & at_zero) == '0)
            else $error("flit sent to an output vc with no credits");
    end

    if (STATUS_RULES) begin : g_status
        alloc_release_clash: assert property (@(posedge clk) disable iff (reset)
            (ovc_alloc & ovc_release) == '0)
            else $error("output vc allocated and released in the same cycle");

        release_of_free: assert property (@(posedge clk) disable iff (reset)
            (ovc_release & ~ovc_status) == '0)
            else $error("release of an output vc that is not allocated");
    end

endmodule

// File: verification/tb_ovc_credit.sv
`timescale 1ns/100ps
`include "credit_params.svh"

module tb_ovc_credit;

    localparam int HALF_PERIOD    = 50;
    localparam int RESET_CYCLES   = 8;
    localparam int WORD_W         = $bits(ovc_credit_pkg::grant_bus_t);
    localparam int WORDS_PER_LINE = 8;  // kind, test, grants, 3 strobes, 2 expected
    localparam int MAX_LINES      = 64;

    logic                       clk;
    logic                       reset;
    ovc_credit_pkg::grant_bus_t grants;
    ovc_credit_pkg::ovc_vec_t   credit_in;
    ovc_credit_pkg::ovc_vec_t   ovc_alloc;
    ovc_credit_pkg::ovc_vec_t   sw_grant_ivc;
    ovc_credit_pkg::ovc_vec_t   ovc_available;
    ovc_credit_pkg::ovc_vec_t   assigned_ovc_not_full;

    logic [WORD_W-1:0]           gold_words [MAX_LINES*WORDS_PER_LINE];
    ovc_credit_pkg::golden_rec_t gold_recs  [MAX_LINES];
    int                          num_lines;
    bit                          loaded;
    int                          tests_passed;
    int                          tests_failed;
    int                          test_checks;
    int                          test_errors;

    ovc_credit_top dut0 (
        .clk                   (clk),
        .reset                 (reset),
        .grants                (grants),
        .credit_in             (credit_in),
        .ovc_alloc             (ovc_alloc),
        .sw_grant_ivc          (sw_grant_ivc),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

    // counter rules need the decrement and count of this scope
    bind credit_tracker ovc_credit_props #(
        .CREDIT_RULES (1'b1),
        .STATUS_RULES (1'b0)
    ) u_credit_props (
        .clk          (clk),
        .reset        (reset),
        .decrement    (decrement),
        .credit_in    (credit_in),
        .credit_count (credit_count),
        .ovc_alloc    ('0),
        .ovc_release  ('0),
        .ovc_status   ('0)
    );

    // allocation rules against the registered status bits
    bind ovc_status_tracker ovc_credit_props #(
        .CREDIT_RULES (1'b0),
        .STATUS_RULES (1'b1)
    ) u_status_props (
        .clk          (clk),
        .reset        (reset),
        .decrement    ('0),
        .credit_in    ('0),
        .credit_count (),
        .ovc_alloc    (ovc_alloc),
        .ovc_release  (ovc_release),
        .ovc_status   (ovc_status)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic bit is_valid_kind(logic [WORD_W-1:0] w);
        logic [3:0] k;
        k = w[3:0];
        return (w[WORD_W-1:4] == '0) && (k == ovc_credit_pkg::GOLD_STIM ||
            k == ovc_credit_pkg::GOLD_CHECK || k == ovc_credit_pkg::GOLD_END);
    endfunction

    function automatic ovc_credit_pkg::golden_rec_t unpack_line(int n);
        ovc_credit_pkg::golden_rec_t r;
        int b;
        b              = n * WORDS_PER_LINE;
        r.kind         = ovc_credit_pkg::golden_kind_e'(gold_words[b][3:0]);
        r.test_id      = gold_words[b+1][7:0];
        r.grants       = gold_words[b+2];
        r.credit_in    = gold_words[b+3][`NUM_OVCS-1:0];
        r.ovc_alloc    = gold_words[b+4][`NUM_OVCS-1:0];
        r.sw_grant_ivc = gold_words[b+5][`NUM_OVCS-1:0];
        r.exp_available = gold_words[b+6][`NUM_OVCS-1:0];
        r.exp_not_full  = gold_words[b+7][`NUM_OVCS-1:0];
        return r;
    endfunction

    task automatic load_golden();
        int a;
        int n;
        // unused slots get an address tag that is never a valid kind
        for (a = 0; a < MAX_LINES*WORDS_PER_LINE; a++) begin
            gold_words[a] = WORD_W'({a, 4'h0});
        end
        $readmemh("verification/ovc_credit_golden.mem", gold_words);
        n = 0;
        while (n < MAX_LINES && is_valid_kind(gold_words[n*WORDS_PER_LINE])) begin
            gold_recs[n] = unpack_line(n);
            n++;
        end
        num_lines = n;
    endtask

    task automatic drive_stimulus(ovc_credit_pkg::golden_rec_t r);
        grants       = r.grants;
        credit_in    = r.credit_in;
        ovc_alloc    = r.ovc_alloc;
        sw_grant_ivc = r.sw_grant_ivc;
    endtask

    task automatic check_outputs(ovc_credit_pkg::golden_rec_t r, int line);
        test_checks++;
        assert (ovc_available === r.exp_available) else begin
            $display("FAIL test %02h line %0d: ovc_available expected 0x%05h, got 0x%05h",
                     r.test_id, line, r.exp_available, ovc_available);
            test_errors++;
        end
        assert (assigned_ovc_not_full === r.exp_not_full) else begin
            $display("FAIL test %02h line %0d: assigned_ovc_not_full expected 0x%05h, got 0x%05h",
                     r.test_id, line, r.exp_not_full, assigned_ovc_not_full);
            test_errors++;
        end
    endtask

    task automatic finish_test(logic [7:0] id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %02h passed, %0d checks", id, test_checks);
        end else begin
            tests_failed++;
            $display("test %02h failed, %0d errors in %0d checks", id, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int i;
        ovc_credit_pkg::golden_rec_t r;
        clk          = 1'b0;
        reset        = 1'b1;
        grants       = '0;
        credit_in    = '0;
        ovc_alloc    = '0;
        sw_grant_ivc = '0;
        tests_passed = 0;
        tests_failed = 0;
        test_checks  = 0;
        test_errors  = 0;
        load_golden();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (i = 0; i < num_lines; i++) begin
            r = gold_recs[i];
            if (r.kind == ovc_credit_pkg::GOLD_END) begin
                finish_test(r.test_id);
            end else begin
                @(negedge clk);
                drive_stimulus(r);
                @(posedge clk);
                #(HALF_PERIOD - 10);  // just before the next falling edge
                if (r.kind == ovc_credit_pkg::GOLD_CHECK) begin
                    check_outputs(r, i);
                end
            end
        end
        if (num_lines == 0) begin
            $display("golden file holds no usable lines");
            tests_failed++;
        end
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(num_lines) * 100 + 2000;
        #(limit_ns);
        $display("timeout: golden playback still running after %0d ns", limit_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: verification/ovc_credit_golden.mem
// kind test grants credit_in ovc_alloc sw_grant_ivc exp_available exp_not_full
// kind 1 drives, 2 drives then checks, f closes the test; ovc bit = port*4 + vc
// port 0 ivc 0 holds port 1 vc 2 (bit 6): 02000041 assigned, 22000041 body, 22100041 tail
// test 01 reset values
2 01 0 00000 00000 00000 fffff fffff
f 01 0 00000 00000 00000 00000 00000
// test 02 allocation clears availability
2 02 0 00000 00040 00000 fffbf fffff
2 02 0 00000 00000 00000 fffbf fffff
f 02 0 00000 00000 00000 00000 00000
// test 03 tail flit releases the vc with two credits left, credits come back
2 03 22100041 00000 00000 00001 fffff fffff
2 03 0 00040 00000 00000 fffff fffff
2 03 0 00040 00000 00000 fffff fffff
f 03 0 00000 00000 00000 00000 00000
// test 04 alloc and two body flits leave one credit, tail paired with a credit
2 04 0 00000 00040 00000 fffbf fffff
2 04 22000041 00000 00000 00001 fffbf fffff
2 04 22000041 00000 00000 00001 fffbf fffff
2 04 22100041 00040 00000 00001 fffbf fffff
2 04 0 00040 00000 00000 fffff fffff
1 04 0 00040 00000 00000 fffff fffff
1 04 0 00040 00000 00000 fffff fffff
f 04 0 00000 00000 00000 00000 00000
// test 05 send and credit in one cycle keep the count
1 05 0 00000 00040 00000 fffbf fffff
2 05 22000041 00040 00000 00001 fffbf fffff
2 05 22000041 00000 00000 00001 fffbf fffff
2 05 22100041 00040 00000 00001 fffff fffff
1 05 0 00040 00000 00000 fffff fffff
1 05 0 00040 00000 00000 fffff fffff
f 05 0 00000 00000 00000 00000 00000
// test 06 not-full mask of ivc 0, nearly full with grant, then empty
1 06 02000041 00000 00040 00000 fffbf fffff
2 06 22000041 00000 00000 00001 fffbf fffff
2 06 22000041 00000 00000 00001 fffbf fffff
2 06 22000041 00000 00000 00001 fffbf ffffe
2 06 02000041 00000 00000 00000 fffbf ffffe
2 06 02000041 00040 00000 00000 fffbf fffff
2 06 02000041 00000 00000 00000 fffbf fffff
2 06 22100041 00040 00000 00001 fffbf fffff
2 06 0 00040 00000 00000 fffff fffff
1 06 0 00040 00000 00000 fffff fffff
1 06 0 00040 00000 00000 fffff fffff
f 06 0 00000 00000 00000 00000 00000

// File: sim.f
+incdir+.
rtl/ovc_credit_pkg.sv
rtl/grant_decode.sv
rtl/credit_tracker.sv
rtl/ovc_status_tracker.sv
rtl/ovc_readiness.sv
rtl/ovc_credit_top.sv
verification/ovc_credit_props.sv
verification/tb_ovc_credit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ovc_credit
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
